// ==== source/fpMacros.svh ====
`ifndef FP_MACROS_SVH
`define FP_MACROS_SVH

// Half-precision field layout
`define FP_EXP_W 5 // Exponent bits
`define FP_MAN_W 10 // Stored mantissa bits
`define FP_WIDTH 16 // Sign, exponent, mantissa

// Exponent encoding
`define FP_BIAS 15
`define FP_EXP_MAX 31 // All ones, inf or NaN

// Quiet NaN produced for every invalid case
`define FP_QNAN 16'h7E00

// Working significand inside the pipeline
// Hidden bit, mantissa, then guard, round and sticky
`define FP_SIG_W 14

`endif

// ==== source/fpFormatPkg.sv ====
`include "fpMacros.svh"

package fpFormatPkg;

	// Raw operand or result word
	typedef logic [`FP_WIDTH-1:0] fpWord;

	typedef logic [`FP_EXP_W-1:0] fpExp; // Biased exponent
	typedef logic [`FP_MAN_W-1:0] fpMan; // Stored fraction

	// Hidden bit, fraction and three low bits for rounding
	typedef logic [`FP_SIG_W-1:0] fpSig;

	// Requested operation
	typedef enum logic {
		fpAdd = 1'b0,
		fpSub = 1'b1
	} fpOpcode;

	// Operand class, also reused as the special-case code downstream
	typedef enum logic [1:0] {
		clsZero = 2'd0, // Zero or subnormal
		clsNormal = 2'd1, // Ordinary number, no special result
		clsInf = 2'd2,
		clsNan = 2'd3
	} fpClass;

endpackage

// ==== source/fpFlagsPkg.sv ====
package fpFlagsPkg;

	// Exception flags, one bit per condition
	typedef logic [3:0] fpFlags;

	// Bit position of each flag inside fpFlags
	typedef enum logic [1:0] {
		flagInexact = 2'd0, // Discarded bits were nonzero
		flagInvalid = 2'd1, // NaN operand or inf - inf
		flagUnderflow = 2'd2, // Flushed to signed zero
		flagOverflow = 2'd3 // Rounded to signed infinity
	} fpFlagIdx;

	// Flags for a result that is exact and finite
	localparam fpFlags flagsNone = 4'b0000;

	// Inexact and overflow together, as produced on overflow
	localparam fpFlags flagsOverflow = 4'b1001;

	// Inexact and underflow together
	localparam fpFlags flagsUnderflow = 4'b0101;

endpackage

// ==== source/fpUnpackStage.sv ====
`include "fpMacros.svh"

module fpUnpackStage (
	input logic clk,
	input logic rst,
	input logic inValid,
	output logic inReady,
	input fpFormatPkg::fpWord a,
	input fpFormatPkg::fpWord b,
	input fpFormatPkg::fpOpcode op,
	output fpFormatPkg::fpClass prepSpecial, // clsNan, clsInf or clsNormal
	output logic prepSign, // Sign of the larger operand
	output logic prepSub, // Effective subtract
	output fpFormatPkg::fpExp prepExp, // Larger exponent
	output fpFormatPkg::fpSig prepLarge,
	output fpFormatPkg::fpSig prepSmall,
	output fpFormatPkg::fpExp prepDiff, // Exponent difference, never negative
	output logic outValid,
	input logic outReady
);
	import fpFormatPkg::*;

	fpClass clsA;
	fpClass clsB;
	fpClass specialNext;
	logic signA;
	logic signB;
	logic [`FP_WIDTH-2:0] keyA; // Magnitude, subnormals forced to zero
	logic [`FP_WIDTH-2:0] keyB;
	logic [`FP_WIDTH-2:0] largeKey;
	logic [`FP_WIDTH-2:0] smallKey;
	logic aLarger;

	function automatic fpClass classify(input fpWord w);
		fpExp e;
		fpMan m;
		e = w[`FP_WIDTH-2:`FP_MAN_W];
		m = w[`FP_MAN_W-1:0];
		if (e == fpExp'(`FP_EXP_MAX)) begin
			if (m != '0) begin
				return clsNan;
			end
			return clsInf;
		end
		if (e == '0) begin
			return clsZero; // Subnormals count as zero
		end
		return clsNormal;
	endfunction

	// Hidden bit only when exponent nonzero, GRS start clear
	function automatic fpSig sigOf(input logic [`FP_WIDTH-2:0] key);
		return {|key[`FP_WIDTH-2:`FP_MAN_W], key[`FP_MAN_W-1:0], 3'b000};
	endfunction

	always_comb begin
		signA = a[`FP_WIDTH-1];
		signB = b[`FP_WIDTH-1] ^ (op == fpSub); // Subtract flips B
		clsA = classify(a);
		clsB = classify(b);
		keyA = (clsA == clsZero) ? '0 : a[`FP_WIDTH-2:0];
		keyB = (clsB == clsZero) ? '0 : b[`FP_WIDTH-2:0];
		aLarger = (keyA >= keyB); // Ties keep A
		largeKey = aLarger ? keyA : keyB;
		smallKey = aLarger ? keyB : keyA;

		// Special-case resolution
		if (clsA == clsNan || clsB == clsNan) begin
			specialNext = clsNan;
		end else if (clsA == clsInf && clsB == clsInf && signA != signB) begin
			specialNext = clsNan; // inf - inf
		end else if (clsA == clsInf || clsB == clsInf) begin
			specialNext = clsInf; // Infinity is always the larger key
		end else begin
			specialNext = clsNormal;
		end
	end

	assign inReady = !outValid || outReady; // Empty slot or draining

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (inReady) begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (inValid && inReady) begin
			prepSpecial <= specialNext;
			prepSign <= aLarger ? signA : signB;
			prepSub <= signA ^ signB;
			prepExp <= largeKey[`FP_WIDTH-2:`FP_MAN_W];
			prepLarge <= sigOf(largeKey);
			prepSmall <= sigOf(smallKey);
			prepDiff <= largeKey[`FP_WIDTH-2:`FP_MAN_W] - smallKey[`FP_WIDTH-2:`FP_MAN_W];
		end
	end

	// Stalled slot keeps its contents
	holdStable: assert property (@(posedge clk) disable iff (rst)
		outValid && !outReady |=> outValid && $stable({prepSpecial, prepSign, prepSub,
			prepExp, prepLarge, prepSmall, prepDiff}));

endmodule

// ==== source/fpAlignStage.sv ====
`include "fpMacros.svh"

module fpAlignStage (
	input logic clk,
	input logic rst,
	input logic inValid,
	output logic inReady,
	input fpFormatPkg::fpClass prepSpecial,
	input logic prepSign,
	input logic prepSub,
	input fpFormatPkg::fpExp prepExp,
	input fpFormatPkg::fpSig prepLarge,
	input fpFormatPkg::fpSig prepSmall,
	input fpFormatPkg::fpExp prepDiff,
	output fpFormatPkg::fpClass alnSpecial,
	output logic alnSign,
	output logic alnSub,
	output fpFormatPkg::fpExp alnExp,
	output fpFormatPkg::fpSig alnLarge,
	output fpFormatPkg::fpSig alnSmall, // Shifted, sticky in bit 0
	output logic outValid,
	input logic outReady
);
	import fpFormatPkg::*;

	fpExp shiftAmt; // Saturated shift
	logic [2*`FP_SIG_W-1:0] shifted; // Upper half kept, lower half lost
	fpSig alignedNext;

	always_comb begin
		// Beyond the significand width everything lands in sticky
		shiftAmt = (prepDiff > fpExp'(`FP_SIG_W)) ? fpExp'(`FP_SIG_W) : prepDiff;
		shifted = {prepSmall, {`FP_SIG_W{1'b0}}} >> shiftAmt;
		alignedNext = shifted[2*`FP_SIG_W-1:`FP_SIG_W];
		alignedNext[0] = alignedNext[0] | (|shifted[`FP_SIG_W-1:0]); // Fold lost bits
	end

	assign inReady = !outValid || outReady;

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (inReady) begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (inValid && inReady) begin
			alnSpecial <= prepSpecial;
			alnSign <= prepSign;
			alnSub <= prepSub;
			alnExp <= prepExp;
			alnLarge <= prepLarge;
			alnSmall <= alignedNext;
		end
	end

	// Operand ordering from the unpack stage survives the shift
	smallerStays: assert property (@(posedge clk) disable iff (rst)
		outValid |-> alnSmall <= alnLarge);

endmodule

// ==== source/fpAddStage.sv ====
`include "fpMacros.svh"

module fpAddStage (
	input logic clk,
	input logic rst,
	input logic inValid,
	output logic inReady,
	input fpFormatPkg::fpClass alnSpecial,
	input logic alnSign,
	input logic alnSub,
	input fpFormatPkg::fpExp alnExp,
	input fpFormatPkg::fpSig alnLarge,
	input fpFormatPkg::fpSig alnSmall,
	output fpFormatPkg::fpClass sumSpecial,
	output logic sumSign,
	output fpFormatPkg::fpExp sumExp,
	output logic [`FP_SIG_W:0] sumRaw, // Carry bit on top
	output logic sumZeroNeg, // Sign of an exact zero
	output logic outValid,
	input logic outReady
);
	logic [`FP_SIG_W:0] largeExt;
	logic [`FP_SIG_W:0] smallExt;
	logic [`FP_SIG_W:0] rawNext;

	always_comb begin
		largeExt = {1'b0, alnLarge};
		smallExt = {1'b0, alnSmall};
		// Larger minus smaller, so no borrow out
		if (alnSub) begin
			rawNext = largeExt - smallExt;
		end else begin
			rawNext = largeExt + smallExt;
		end
	end

	assign inReady = !outValid || outReady;

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (inReady) begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (inValid && inReady) begin
			sumSpecial <= alnSpecial;
			sumSign <= alnSign;
			sumExp <= alnExp;
			sumRaw <= rawNext;
			sumZeroNeg <= alnSign & ~alnSub; // Both operands negative
		end
	end

endmodule

// ==== source/fpNormRoundStage.sv ====
`include "fpMacros.svh"

module fpNormRoundStage (
	input logic clk,
	input logic rst,
	input logic inValid,
	output logic inReady,
	input fpFormatPkg::fpClass sumSpecial,
	input logic sumSign,
	input fpFormatPkg::fpExp sumExp,
	input logic [`FP_SIG_W:0] sumRaw,
	input logic sumZeroNeg,
	output fpFormatPkg::fpWord result,
	output fpFlagsPkg::fpFlags flags,
	output logic outValid,
	input logic outReady
);
	import fpFormatPkg::*;
	import fpFlagsPkg::*;

	localparam logic signed [`FP_EXP_W+1:0] expTop = 7'(2 * `FP_BIAS); // Largest finite

	logic [3:0] lz; // Leading zeros below the carry bit
	fpSig norm; // Hidden bit at the top
	logic signed [`FP_EXP_W+1:0] normExp; // Room for carry and negatives
	logic signed [`FP_EXP_W+1:0] rndExp;
	logic guardBit;
	logic roundBit;
	logic stickyBit;
	logic roundUp;
	logic [`FP_MAN_W:0] manRnd; // Top bit is mantissa carry
	fpWord resultNext;
	fpFlags flagsNext;

	always_comb begin
		// Leading one search, highest set bit wins
		lz = '0;
		for (int i = 0; i < `FP_SIG_W; i++) begin
			if (sumRaw[i]) begin
				lz = 4'(`FP_SIG_W - 1 - i);
			end
		end

		if (sumRaw[`FP_SIG_W]) begin // Carry out, one right
			norm = {sumRaw[`FP_SIG_W:2], sumRaw[1] | sumRaw[0]};
			normExp = $signed({2'b00, sumExp}) + 7'sd1;
		end else begin
			norm = sumRaw[`FP_SIG_W-1:0] << lz;
			normExp = $signed({2'b00, sumExp}) - $signed({3'b000, lz});
		end

		guardBit = norm[2];
		roundBit = norm[1];
		stickyBit = norm[0];
		roundUp = guardBit & (roundBit | stickyBit | norm[3]); // Ties to even
		manRnd = {1'b0, norm[`FP_SIG_W-2:3]} + {{`FP_MAN_W{1'b0}}, roundUp};
		rndExp = normExp + $signed({6'b000000, manRnd[`FP_MAN_W]}); // All-ones mantissa wraps

		// Ordinary finite result first, specials override below
		resultNext = {sumSign, rndExp[`FP_EXP_W-1:0], manRnd[`FP_MAN_W-1:0]};
		flagsNext = flagsNone;
		flagsNext[flagInexact] = guardBit | roundBit | stickyBit;

		if (sumSpecial == clsNan) begin
			resultNext = `FP_QNAN;
			flagsNext = flagsNone;
			flagsNext[flagInvalid] = 1'b1;
		end else if (sumSpecial == clsInf) begin
			resultNext = {sumSign, fpExp'(`FP_EXP_MAX), {`FP_MAN_W{1'b0}}};
			flagsNext = flagsNone; // Exact infinity
		end else if (sumRaw == '0) begin
			resultNext = {sumZeroNeg, {(`FP_WIDTH-1){1'b0}}};
			flagsNext = flagsNone;
		end else if (normExp < 7'sd1) begin
			// Below normal range, flush
			resultNext = {sumSign, {(`FP_WIDTH-1){1'b0}}};
			flagsNext = flagsUnderflow;
		end else if (rndExp > expTop) begin
			resultNext = {sumSign, fpExp'(`FP_EXP_MAX), {`FP_MAN_W{1'b0}}};
			flagsNext = flagsOverflow;
		end
	end

	assign inReady = !outValid || outReady;

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (inReady) begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (inValid && inReady) begin
			result <= resultNext;
			flags <= flagsNext;
		end
	end

	// Output handshake always resolved once out of reset
	knownValid: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(outValid));

endmodule

// ==== source/fpAddSubTop.sv ====
`include "fpMacros.svh"

module fpAddSubTop (
	input logic clk,
	input logic rst,
	input logic inValid,
	output logic inReady,
	input fpFormatPkg::fpWord a,
	input fpFormatPkg::fpWord b,
	input fpFormatPkg::fpOpcode op,
	output logic outValid,
	input logic outReady,
	output fpFormatPkg::fpWord result,
	output fpFlagsPkg::fpFlags flags
);
	import fpFormatPkg::*;

	// Unpack to align
	logic prepValid;
	logic prepReady;
	fpClass prepSpecial;
	logic prepSign;
	logic prepSub;
	fpExp prepExp;
	fpSig prepLarge;
	fpSig prepSmall;
	fpExp prepDiff;

	// Align to add
	logic alnValid;
	logic alnReady;
	fpClass alnSpecial;
	logic alnSign;
	logic alnSub;
	fpExp alnExp;
	fpSig alnLarge;
	fpSig alnSmall;

	// Add to normalize and round
	logic sumValid;
	logic sumReady;
	fpClass sumSpecial;
	logic sumSign;
	fpExp sumExp;
	logic [`FP_SIG_W:0] sumRaw;
	logic sumZeroNeg;

	fpUnpackStage unpack (
		.clk(clk), .rst(rst), .inValid(inValid), .inReady(inReady),
		.a(a), .b(b), .op(op),
		.prepSpecial(prepSpecial), .prepSign(prepSign), .prepSub(prepSub),
		.prepExp(prepExp), .prepLarge(prepLarge), .prepSmall(prepSmall),
		.prepDiff(prepDiff), .outValid(prepValid), .outReady(prepReady)
	);

	fpAlignStage align (
		.clk(clk), .rst(rst), .inValid(prepValid), .inReady(prepReady),
		.prepSpecial(prepSpecial), .prepSign(prepSign), .prepSub(prepSub),
		.prepExp(prepExp), .prepLarge(prepLarge), .prepSmall(prepSmall),
		.prepDiff(prepDiff),
		.alnSpecial(alnSpecial), .alnSign(alnSign), .alnSub(alnSub), .alnExp(alnExp),
		.alnLarge(alnLarge), .alnSmall(alnSmall),
		.outValid(alnValid), .outReady(alnReady)
	);

	fpAddStage add (
		.clk(clk), .rst(rst), .inValid(alnValid), .inReady(alnReady),
		.alnSpecial(alnSpecial), .alnSign(alnSign), .alnSub(alnSub), .alnExp(alnExp),
		.alnLarge(alnLarge), .alnSmall(alnSmall),
		.sumSpecial(sumSpecial), .sumSign(sumSign), .sumExp(sumExp), .sumRaw(sumRaw),
		.sumZeroNeg(sumZeroNeg), .outValid(sumValid), .outReady(sumReady)
	);

	fpNormRoundStage normRound (
		.clk(clk), .rst(rst), .inValid(sumValid), .inReady(sumReady),
		.sumSpecial(sumSpecial), .sumSign(sumSign), .sumExp(sumExp), .sumRaw(sumRaw),
		.sumZeroNeg(sumZeroNeg), .result(result), .flags(flags),
		.outValid(outValid), .outReady(outReady)
	);

endmodule

// ==== verif/fpAddSubModel.svh ====
`ifndef FP_ADD_SUB_MODEL_SVH
`define FP_ADD_SUB_MODEL_SVH

// Operand kind, exponent zero always counts as zero
function automatic fpClass operandKind(input fpWord w);
	fpExp e;
	fpMan m;
	e = w[`FP_WIDTH-2:`FP_MAN_W];
	m = w[`FP_MAN_W-1:0];
	if (e == fpExp'(`FP_EXP_MAX)) begin
		return (m == '0) ? clsInf : clsNan;
	end
	return (e == '0) ? clsZero : clsNormal;
endfunction

// Magnitude in units of 2^-24, the last-bit weight of the smallest normal
function automatic longint scaledValue(input fpWord w);
	longint sig;
	int e;
	e = int'(w[`FP_WIDTH-2:`FP_MAN_W]);
	if (operandKind(w) != clsNormal) begin
		return 0;
	end
	sig = longint'({1'b1, w[`FP_MAN_W-1:0]});
	return sig << (e - 1);
endfunction

// Exact sum, then one rounding to 11 significant bits
function automatic void expectedSum(input fpWord a, input fpWord b, input fpOpcode op,
	output fpWord res, output fpFlags fl);
	fpClass ka;
	fpClass kb;
	logic sa;
	logic sb;
	logic neg;
	longint total;
	longint mag;
	longint mant;
	longint rem;
	longint half;
	int p;
	int bexp;
	int shift;
	ka = operandKind(a);
	kb = operandKind(b);
	sa = a[`FP_WIDTH-1];
	sb = b[`FP_WIDTH-1] ^ (op == fpSub); // Subtract negates B
	fl = '0;
	res = '0;
	if (ka == clsNan || kb == clsNan || (ka == clsInf && kb == clsInf && sa != sb)) begin
		res = `FP_QNAN;
		fl[flagInvalid] = 1'b1;
		return;
	end
	if (ka == clsInf || kb == clsInf) begin
		res = {(ka == clsInf) ? sa : sb, fpExp'(`FP_EXP_MAX), fpMan'(0)};
		return;
	end
	total = (sa ? -scaledValue(a) : scaledValue(a)) + (sb ? -scaledValue(b) : scaledValue(b));
	if (total == 0) begin
		res = {sa & sb, {(`FP_WIDTH-1){1'b0}}}; // Negative only if both were
		return;
	end
	neg = (total < 0);
	mag = neg ? -total : total;
	p = 0;
	for (int i = 0; i < 48; i++) begin
		if (mag[i]) begin
			p = i; // Leading one
		end
	end
	bexp = p - 9;
	if (bexp < 1) begin
		res = {neg, {(`FP_WIDTH-1){1'b0}}};
		fl[flagUnderflow] = 1'b1;
		fl[flagInexact] = 1'b1;
		return;
	end
	shift = p - `FP_MAN_W; // Bits below the kept 11
	mant = mag >> shift;
	rem = mag - (mant << shift);
	half = (shift > 0) ? (longint'(1) << (shift - 1)) : 0;
	fl[flagInexact] = (rem != 0);
	if (shift > 0 && (rem > half || (rem == half && mant[0]))) begin
		mant++; // Nearest, ties to even
	end
	if (mant == 2048) begin
		mant = 1024;
		bexp++;
	end
	if (bexp > 30) begin
		res = {neg, fpExp'(`FP_EXP_MAX), fpMan'(0)};
		fl[flagOverflow] = 1'b1;
		fl[flagInexact] = 1'b1;
		return;
	end
	res = {neg, fpExp'(bexp), mant[`FP_MAN_W-1:0]};
endfunction

`endif

// ==== verif/fpAddSubTb.sv ====
`include "fpMacros.svh"

module fpAddSubTb;
	timeunit 1ns;
	timeprecision 100ps;

	import fpFormatPkg::*;
	import fpFlagsPkg::*;

	`include "fpAddSubModel.svh"

	localparam int numTx = 3000;
	localparam int clkPeriod = 40;
	localparam int stallMargin = 8; // Slowest phase drains about one item in four
	localparam int phaseLen = 250; // Items per outReady phase
	localparam int readyPct[5] = '{100, 60, 25, 90, 40}; // First phase never stalls
	localparam int signBit = `FP_WIDTH - 1;
	localparam fpWord specialWords[8] = '{16'h0000, 16'h8000, 16'h7C00, 16'hFC00,
		16'h7E00, 16'h7C01, 16'hFE55, 16'h03FF};

	logic clk;
	logic rst;
	logic inValid;
	logic inReady;
	fpWord a;
	fpWord b;
	fpOpcode op;
	logic outValid;
	logic outReady;
	fpWord result;
	fpFlags flags;

	integer seed;
	int errors = 0;
	int checks = 0;
	int sent = 0;
	int received = 0;
	int edgeCount = 0;
	int lastLowEdge = -1; // Last edge with outReady low
	logic inTaken = 1'b0; // Input transfer on the last rising edge
	logic [`FP_WIDTH+3:0] expectQ[$]; // Flags above result
	int acceptQ[$]; // Edge where each pending input went in

	fpAddSubTop DUT (
		.clk(clk), .rst(rst), .inValid(inValid), .inReady(inReady),
		.a(a), .b(b), .op(op), .outValid(outValid), .outReady(outReady),
		.result(result), .flags(flags)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("Fail at %0t ns: %s got %h, expected %h", $time, name, got, want);
		end
	endtask

	task automatic closeRun();
		$display("Sent %0d, received %0d, checks %0d, errors %0d", sent, received, checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	endtask

	function automatic int randBelow(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic fpWord withExp(input fpWord w, input int e);
		return {w[signBit], fpExp'(e), w[`FP_MAN_W-1:0]};
	endfunction

	// One operand pair, drawn from a mix of corner regions
	task automatic drawOperands();
		int kind;
		fpWord tmp;
		kind = randBelow(8);
		a = fpWord'($random(seed));
		b = fpWord'($random(seed));
		op = (randBelow(2) == 1) ? fpSub : fpAdd;
		case (kind)
			3: begin // Specials, or a subnormal partner
				a = specialWords[randBelow(8)];
				b = (randBelow(2) == 1) ? specialWords[randBelow(8)] : withExp(b, 0);
				if (randBelow(2) == 1) begin
					tmp = a;
					a = b;
					b = tmp;
				end
			end
			4: begin // Near or exact cancellation
				a = withExp(a, 1 + randBelow(30));
				b = a ^ fpWord'(randBelow(4));
				op = fpSub;
				if (randBelow(2) == 1) begin
					b[signBit] = ~b[signBit];
					op = fpAdd;
				end
			end
			5: begin // Wide exponent gap
				a = withExp(a, 16 + randBelow(15));
				b = withExp(b, 1 + randBelow(15));
			end
			6: begin
				a = withExp(a, 29 + randBelow(2));
				b = withExp(b, 29 + randBelow(2));
				b[signBit] = a[signBit] ^ (op == fpSub); // Effective add, overflow region
			end
			7: begin
				a = withExp(a, 1 + randBelow(2));
				b = withExp(b, 1 + randBelow(2));
				b[signBit] = a[signBit] ^ (op == fpAdd); // Effective subtract near zero
			end
			default: begin
			end
		endcase
	endtask

	// Stimulus on the falling edge
	initial begin
		bit allSent;
		allSent = 1'b0;
		seed = 32'h980633df;
		rst = 1'b1;
		inValid = 1'b0;
		a = '0;
		b = '0;
		op = fpAdd;
		outReady = 1'b1;
		repeat (5) @(posedge clk);
		@(negedge clk);
		checkValue("outValid", 32'(outValid), 32'd0); // Empty pipeline after reset
		checkValue("inReady", 32'(inReady), 32'd1);
		rst = 1'b0;
		while (!allSent) begin
			@(negedge clk);
			outReady = randBelow(100) < readyPct[(sent / phaseLen) % 5];
			if (!inValid || inTaken) begin // Held data only changes after a transfer
				if (sent == numTx) begin
					inValid = 1'b0;
					allSent = 1'b1;
				end else if (randBelow(8) == 0) begin
					inValid = 1'b0; // Bubble
				end else begin
					drawOperands();
					inValid = 1'b1;
					sent++;
				end
			end
		end
		outReady = 1'b1;
		wait (received == numTx);
		repeat (3) @(negedge clk); // Room for a stray extra output
		closeRun();
	end

	// Scoreboard, sampled before the DUT registers update
	always @(posedge clk) begin
		fpWord expRes;
		fpFlags expFlags;
		logic [`FP_WIDTH+3:0] entry;
		int acceptEdge;
		edgeCount++;
		inTaken = 1'b0;
		if (!rst) begin
			if (!outReady) begin
				lastLowEdge = edgeCount;
			end
			// Refuses input only with all four slots full and the output stalled
			checkValue("inReady", 32'(inReady), 32'(!(expectQ.size() == 4 && !outReady)));
			if (outValid && outReady) begin
				if (expectQ.size() == 0) begin
					errors++;
					$display("Output at %0t ns with no accepted input behind it", $time);
				end else begin
					entry = expectQ.pop_front();
					acceptEdge = acceptQ.pop_front();
					received++;
					checkValue("result", 32'(result), 32'(entry[`FP_WIDTH-1:0]));
					checkValue("flags", 32'(flags), 32'(entry[`FP_WIDTH+3:`FP_WIDTH]));
					if (lastLowEdge < acceptEdge) begin // No stall since it went in
						checkValue("latency", 32'(edgeCount - acceptEdge), 32'd4);
					end
				end
			end
			if (inValid && inReady) begin
				expectedSum(a, b, op, expRes, expFlags);
				expectQ.push_back({expFlags, expRes});
				acceptQ.push_back(edgeCount);
				inTaken = 1'b1;
			end
		end
	end

	// Every item at the slowest stall rate, plus reset
	initial begin
		#(numTx * clkPeriod * stallMargin + 20 * clkPeriod);
		errors++;
		$display("Timeout: only %0d of %0d results arrived in time", received, numTx);
		closeRun();
	end

endmodule

// ==== all.f ====
+incdir+source
+incdir+verif
source/fpFormatPkg.sv
source/fpFlagsPkg.sv
source/fpUnpackStage.sv
source/fpAlignStage.sv
source/fpAddStage.sv
source/fpNormRoundStage.sv
source/fpAddSubTop.sv
verif/fpAddSubTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= fpAddSubTb
BUILD_DIR ?= build
FLAGS ?= --binary --timing --assert --timescale 1ns/100ps

SOURCES := $(wildcard source/*.sv source/*.svh verif/*.sv verif/*.svh)
BINARY := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BINARY)

# Rebuilt only when the file list or a source changes
$(BINARY): all.f $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f all.f

# Output held in a shell variable, shown, then searched for the pass line
run: $(BINARY)
	@out="$$($(BINARY))"; echo "$$out"; echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf $(BUILD_DIR)
